/* filelist.f */
hdl/besm_bus_pkg.sv
hdl/bus_ctrl_if.sv
hdl/bus_arbiter.sv
hdl/step_counter.sv
hdl/busio_regs.sv
hdl/bus_memory.sv
hdl/bus_unit.sv
tb/bus_unit_tb.sv

/* hdl/besm_bus_pkg.sv */
package besm_bus_pkg;

    localparam int WORD_W    = 64;              // Machine word width
    localparam int ADDR_W    = 10;              // Memory address width
    localparam int MEM_WORDS = 1024;            // Memory depth in words

    localparam int STEP_W = 3;                  // Step counter width
    localparam logic [STEP_W-1:0] STEP_MAX = 7; // Idle value where the counter saturates

    localparam int SEM_BIT = 55;                // Semaphore bit set by RDMWR

    typedef logic [WORD_W-1:0] word_t;          // Data word
    typedef logic [ADDR_W-1:0] addr_t;          // Physical word address

    // Arbiter operation codes issued by the processor
    typedef enum logic [3:0] {
        OP_IDLE  = 4'd0,                        // No operation
        OP_CCRD  = 4'd1,                        // Instruction cache read
        OP_CCWR  = 4'd2,                        // Instruction cache write
        OP_DCRD  = 4'd3,                        // Operand cache read
        OP_DCWR  = 4'd4,                        // Operand cache write
        OP_RSV5  = 4'd5,                        // Reserved
        OP_RSV6  = 4'd6,                        // Reserved
        OP_RSV7  = 4'd7,                        // Reserved
        OP_FETCH = 4'd8,                        // Instruction fetch
        OP_DRD   = 4'd9,                        // Operand read
        OP_DWR   = 4'd10,                       // Operand write
        OP_RDMWR = 4'd11,                       // Atomic read-modify-write
        OP_BTRWR = 4'd12,                       // Block transfer write
        OP_BTRRD = 4'd13,                       // Block transfer read
        OP_BICLR = 4'd14,                       // Bus interrupt clear
        OP_BIRD  = 4'd15                        // Bus interrupt read
    } bus_op_t;

    // Bus I/O register file index
    typedef enum logic [1:0] {
        REG_ADDR  = 2'd0,                       // Physical address
        REG_CMD   = 2'd1,                       // Fetched instruction
        REG_RDATA = 2'd2,                       // Loaded operand
        REG_WDATA = 2'd3                        // Data to store
    } reg_index_t;

endpackage

/* hdl/bus_arbiter.sv */
`timescale 1ns/1ns

module bus_arbiter import besm_bus_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              request,  // One-cycle start pulse
    input  bus_op_t           opcode,   // Held until done
    input  logic [STEP_W-1:0] step,     // Cycles since request
    bus_ctrl_if.arbiter       ctrl,     // Strobes to data blocks
    output logic              atomic,   // RDMWR in progress
    output logic              block,    // Block transfer op enables address increment
    output logic              done      // No operation running
);

    // One row of the strobe table
    typedef struct packed {
        reg_index_t arx;
        logic       ecx;
        logic       wrx;
        logic       astb;
        logic       rd;
        logic       wr;
        logic       done;
    } strobe_t;

    localparam strobe_t S_IDLE = '{REG_RDATA, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    strobe_t s;                         // Strobes for current step
    logic    block_mode;                // Previous op was a block transfer
    logic    block_op;                  // Current op is a block transfer

    assign block_op = (opcode == OP_BTRWR) || (opcode == OP_BTRRD);
    assign block    = block_op;         // Address moves on after every block transfer
    assign atomic   = (opcode == OP_RDMWR);

    // Flag follows the opcode while idle so any other op ends block mode
    always_ff @(posedge clk) begin
        if (reset) begin
            block_mode <= 1'b0;
        end else if (done && !request) begin
            block_mode <= block_op;
        end
    end

    always_comb begin
        s = S_IDLE;                     // Done once the steps run out
        if (!request) begin             // Step value is stale on the request cycle
            case (opcode)
                OP_FETCH: begin
                    case (step)
                        0: s = '{REG_ADDR,  1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0}; // Send address
                        1: s = '{REG_CMD,   1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0}; // Read word
                        2: s = '{REG_CMD,   1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0}; // Load CMD
                        default: ;
                    endcase
                end
                OP_DRD: begin
                    case (step)
                        0: s = '{REG_ADDR,  1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0}; // Send address
                        1: s = '{REG_RDATA, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0}; // Read word
                        2: s = '{REG_RDATA, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0}; // Load RDATA
                        default: ;
                    endcase
                end
                OP_DWR: begin
                    case (step)
                        0: s = '{REG_ADDR,  1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0}; // Send address
                        1: s = '{REG_WDATA, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0}; // Present data
                        2: s = '{REG_WDATA, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0}; // Write word
                        default: ;
                    endcase
                end
                OP_RDMWR: begin
                    // Old word lands in RDATA and goes back with the semaphore set
                    case (step)
                        0: s = '{REG_ADDR,  1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0}; // Send address
                        1: s = '{REG_RDATA, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0}; // Read word
                        2: s = '{REG_RDATA, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0}; // Load RDATA
                        3: s = '{REG_RDATA, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0}; // Present RDATA
                        4: s = '{REG_RDATA, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0}; // Write back
                        default: ;
                    endcase
                end
                OP_BTRWR: begin
                    if (block_mode) begin                                      // No address phase
                        case (step)
                            0: s = '{REG_WDATA, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
                            1: s = '{REG_WDATA, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
                            default: ;
                        endcase
                    end else begin
                        case (step)
                            0: s = '{REG_ADDR,  1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
                            1: s = '{REG_WDATA, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
                            2: s = '{REG_WDATA, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
                            default: ;
                        endcase
                    end
                end
                OP_BTRRD: begin
                    if (block_mode) begin                                      // Next word
                        case (step)
                            0: s = '{REG_RDATA, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
                            1: s = '{REG_RDATA, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
                            default: ;
                        endcase
                    end else begin
                        case (step)
                            0: s = '{REG_ADDR,  1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
                            1: s = '{REG_RDATA, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
                            2: s = '{REG_RDATA, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
                            default: ;
                        endcase
                    end
                end
                default: ;              // Cache and interrupt ops finish at once
            endcase
        end
    end

    assign ctrl.arx  = s.arx;
    assign ctrl.ecx  = s.ecx;
    assign ctrl.wrx  = s.wrx;
    assign ctrl.astb = s.astb;
    assign ctrl.rd   = s.rd;
    assign ctrl.wr   = s.wr;
    assign done      = s.done;

endmodule

/* hdl/bus_ctrl_if.sv */
`timescale 1ns/1ns

// Strobes from the arbiter to the register file and the memory
interface bus_ctrl_if import besm_bus_pkg::*; ();

    reg_index_t arx;    // Register select
    logic       ecx;    // Register port enable
    logic       wrx;    // Load memory word into selected register
    logic       astb;   // Latch REG_ADDR into memory address
    logic       rd;     // Memory read
    logic       wr;     // Memory write

    modport arbiter (
        output arx,
        output ecx,
        output wrx,
        output astb,
        output rd,
        output wr
    );

    modport data (
        input  arx,
        input  ecx,
        input  wrx,
        input  astb,
        input  rd,
        input  wr
    );

endinterface

/* hdl/bus_memory.sv */
`timescale 1ns/1ns

module bus_memory import besm_bus_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    bus_ctrl_if.data  ctrl,
    input  logic      block,        // Steps the address after each block access
    input  addr_t     addr_word,    // REG_ADDR contents
    input  word_t     reg_word,     // Data to write
    output word_t     mem_word      // Read data valid the cycle after rd
);

    word_t mem [MEM_WORDS];         // Filled by writes only
    addr_t addr_q;                  // Address latch
    word_t rd_word;

    assign rd_word = mem[addr_q];   // Array read straight from the latch

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_q <= '0;
        end else if (ctrl.astb) begin
            addr_q <= addr_word;
        end else if (block && (ctrl.rd || ctrl.wr)) begin
            addr_q <= addr_q + 1'b1;            // Next word of the block
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.wr) begin
            mem[addr_q] <= reg_word;
        end
        if (ctrl.rd) begin
            mem_word <= rd_word;                // Held for the wrx step
        end
    end

endmodule

/* hdl/bus_unit.sv */
`timescale 1ns/1ns

module bus_unit import besm_bus_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    request,    // One-cycle pulse only while done
    input  bus_op_t opcode,     // Held until done
    input  addr_t   addr,       // Sampled with request
    input  word_t   wdata,      // Sampled with request
    output logic    done,
    output word_t   rdata,      // Valid once done rises
    output word_t   cmd         // Valid once done rises
);

    logic [STEP_W-1:0] step;
    logic              atomic;
    logic              block;
    addr_t             addr_word;
    word_t             reg_word;
    word_t             mem_word;

    bus_ctrl_if ctrl ();        // Arbiter strobes

    bus_arbiter u_arbiter (
        .clk     (clk),
        .reset   (reset),
        .request (request),
        .opcode  (opcode),
        .step    (step),
        .ctrl    (ctrl.arbiter),
        .atomic  (atomic),
        .block   (block),
        .done    (done)
    );

    step_counter u_step (
        .clk     (clk),
        .reset   (reset),
        .restart (request),
        .advance (!done),       // Runs only while an op is in progress
        .step    (step)
    );

    busio_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .load      (request),
        .addr      (addr),
        .wdata     (wdata),
        .ctrl      (ctrl.data),
        .atomic    (atomic),
        .mem_word  (mem_word),
        .addr_word (addr_word),
        .reg_word  (reg_word),
        .rdata     (rdata),
        .cmd       (cmd)
    );

    bus_memory u_mem (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl.data),
        .block     (block),
        .addr_word (addr_word),
        .reg_word  (reg_word),
        .mem_word  (mem_word)
    );

endmodule

/* hdl/busio_regs.sv */
`timescale 1ns/1ns

module busio_regs import besm_bus_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      load,         // Client request
    input  addr_t     addr,         // Client address
    input  word_t     wdata,        // Client store data
    bus_ctrl_if.data  ctrl,
    input  logic      atomic,       // Force semaphore bit on write back
    input  word_t     mem_word,     // Word read from memory
    output addr_t     addr_word,    // To memory address latch
    output word_t     reg_word,     // Selected register toward memory
    output word_t     rdata,        // Last operand read
    output word_t     cmd           // Last instruction fetched
);

    word_t regs [4];                // Indexed by reg_index_t

    always_ff @(posedge clk) begin
        if (reset) begin
            foreach (regs[i]) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[REG_ADDR]  <= word_t'(addr);   // Zero-extended
            regs[REG_WDATA] <= wdata;
        end else if (ctrl.ecx && ctrl.wrx) begin
            regs[ctrl.arx] <= mem_word;         // CMD or RDATA in practice
        end
    end

    // Port drives zero when not enabled
    always_comb begin
        reg_word = '0;
        if (ctrl.ecx) begin
            reg_word = regs[ctrl.arx];
            if (atomic) begin
                reg_word[SEM_BIT] = 1'b1;       // Semaphore lock
            end
        end
    end

    assign addr_word = regs[REG_ADDR][ADDR_W-1:0];
    assign rdata     = regs[REG_RDATA];
    assign cmd       = regs[REG_CMD];

endmodule

/* hdl/step_counter.sv */
`timescale 1ns/1ns

module step_counter import besm_bus_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              restart,  // Request pulse
    input  logic              advance,  // Operation still running
    output logic [STEP_W-1:0] step
);

    // Parks at STEP_MAX after reset so the arbiter sees no active step
    always_ff @(posedge clk) begin
        if (reset) begin
            step <= STEP_MAX;
        end else if (restart) begin
            step <= '0;                             // First step follows the request
        end else if (advance && (step != STEP_MAX)) begin
            step <= step + 1'b1;
        end
    end

endmodule

/* tb/bus_unit_tb.sv */
`timescale 1ns/1ns

module bus_unit_tb import besm_bus_pkg::*; ();

    localparam int CLK_PERIOD  = 8;                 // ns
    localparam int MAX_OPS     = 300;               // Upper bound on requests issued
    localparam int OP_TIMEOUT  = 20;                // Cycles allowed for done to rise
    localparam int WATCHDOG_NS = MAX_OPS * 10 * CLK_PERIOD + 200 * CLK_PERIOD;

    logic    clk;
    logic    reset;
    logic    request;
    bus_op_t opcode;
    addr_t   addr;
    word_t   wdata;
    logic    done;
    word_t   rdata;
    word_t   cmd;

    int      seed   = 43;                           // Fixed stimulus seed
    int      errors = 0;
    int      checks = 0;
    int      ops    = 0;
    string   test_name;

    word_t   model_mem [addr_t];                    // Words written so far
    addr_t   written_q [$];                         // Keys of model_mem for random picks
    word_t   exp_rdata;
    word_t   exp_cmd;
    logic    model_blk;                             // Previous op was a block transfer
    addr_t   blk_addr;                              // Next word of the running block

    bus_unit dut (
        .clk     (clk),
        .reset   (reset),
        .request (request),
        .opcode  (opcode),
        .addr    (addr),
        .wdata   (wdata),
        .done    (done),
        .rdata   (rdata),
        .cmd     (cmd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Hard stop if some wait never returns
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic addr_t rand_addr();
        return addr_t'($random(seed));
    endfunction

    function automatic word_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // Any address already holding a known word
    function automatic addr_t pick_written();
        int idx;
        idx = $unsigned($random(seed)) % written_q.size();
        return written_q[idx];
    endfunction

    // Opcodes 0..7, 14, 15
    function automatic bus_op_t rand_unimpl();
        int         k;
        logic [3:0] code;
        k = $unsigned($random(seed)) % 10;
        code = (k < 8) ? 4'(k) : 4'(k + 6);
        return bus_op_t'(code);
    endfunction

    task automatic write_model(input addr_t a, input word_t w);
        if (!model_mem.exists(a)) begin
            written_q.push_back(a);
        end
        model_mem[a] = w;
    endtask

    task automatic read_model(input addr_t a, output word_t w);
        if (model_mem.exists(a)) begin
            w = model_mem[a];
        end else begin
            w = 'x;
            errors++;
            $display("Test %s read address %h that was never written", test_name, a);
        end
    endtask

    // One request, model update, wait for done, then compare
    task automatic run_op(input bus_op_t op, input addr_t a, input word_t d);
        int    exp_lat;
        int    lat;
        addr_t acc;
        word_t w;
        logic  impl;
        exp_lat = 0;
        impl    = 1'b1;
        case (op)
            OP_FETCH: begin
                exp_lat = 3;
                read_model(a, w);
                exp_cmd = w;
            end
            OP_DRD: begin
                exp_lat = 3;
                read_model(a, w);
                exp_rdata = w;
            end
            OP_DWR: begin
                exp_lat = 3;
                write_model(a, d);
            end
            OP_RDMWR: begin
                exp_lat = 5;
                read_model(a, w);
                exp_rdata  = w;                     // Old word comes back
                w[SEM_BIT] = 1'b1;
                write_model(a, w);
            end
            OP_BTRWR: begin
                acc     = model_blk ? blk_addr : a; // Address phase only on first transfer
                exp_lat = model_blk ? 2 : 3;
                write_model(acc, d);
                blk_addr = acc + 1'b1;
            end
            OP_BTRRD: begin
                acc     = model_blk ? blk_addr : a;
                exp_lat = model_blk ? 2 : 3;
                read_model(acc, w);
                exp_rdata = w;
                blk_addr  = acc + 1'b1;
            end
            default: begin
                impl = 1'b0;                        // Done stays high
            end
        endcase
        model_blk = (op == OP_BTRWR) || (op == OP_BTRRD);

        @(posedge clk);
        request <= 1'b1;
        opcode  <= op;
        addr    <= a;
        wdata   <= d;
        @(posedge clk);
        request <= 1'b0;
        ops++;

        lat = 0;
        @(negedge clk);
        while (!done && lat < OP_TIMEOUT) begin
            lat++;
            @(negedge clk);
        end
        if (!done) begin
            errors++;
            $display("Test %s: done never rose for opcode %0d within %0d cycles",
                     test_name, op, OP_TIMEOUT);
        end

        if (!impl) begin                            // Done must not dip later either
            repeat (2) begin
                @(negedge clk);
                checks++;
                if (done !== 1'b1) begin
                    errors++;
                    $display("Test %s: done dropped during unimplemented opcode %0d",
                             test_name, op);
                end
            end
        end

        checks++;
        if (lat != exp_lat) begin
            errors++;
            $display("[ERROR] %s: opcode %0d latency expected %0d, actual %0d",
                     test_name, op, exp_lat, lat);
        end
        checks++;
        if (rdata !== exp_rdata) begin
            errors++;
            $display("[ERROR] %s: opcode %0d rdata expected %h, actual %h",
                     test_name, op, exp_rdata, rdata);
        end
        checks++;
        if (cmd !== exp_cmd) begin
            errors++;
            $display("[ERROR] %s: opcode %0d cmd expected %h, actual %h",
                     test_name, op, exp_cmd, cmd);
        end
    endtask

    initial begin
        addr_t a;
        addr_t start;
        int    len;

        reset     = 1'b1;
        request   = 1'b0;
        opcode    = OP_IDLE;
        addr      = '0;
        wdata     = '0;
        exp_rdata = '0;                             // Registers clear on reset
        exp_cmd   = '0;
        model_blk = 1'b0;
        blk_addr  = '0;

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Write then read back
        test_name = "dwr_drd";
        repeat (40) begin
            a = rand_addr();
            run_op(OP_DWR, a, rand_word());
            run_op(OP_DRD, a, rand_word());
        end

        // Instruction fetch leaves rdata alone
        test_name = "fetch";
        repeat (20) begin
            run_op(OP_FETCH, pick_written(), rand_word());
        end

        // Semaphore set on write back
        test_name = "rdmwr";
        repeat (10) begin
            a = pick_written();
            run_op(OP_RDMWR, a, rand_word());
            run_op(OP_DRD, a, rand_word());
        end

        repeat (6) begin
            start = rand_addr();
            len   = 2 + int'($unsigned($random(seed)) % 7);

            test_name = "btrwr_run";
            run_op(OP_BTRWR, start, rand_word());
            for (int i = 1; i < len; i++) begin
                run_op(OP_BTRWR, rand_addr(), rand_word()); // Address ignored in block mode
            end

            test_name = "unimpl";
            run_op(rand_unimpl(), rand_addr(), rand_word());

            test_name = "btrrd_run";
            run_op(OP_BTRRD, start, rand_word());
            for (int i = 1; i < len; i++) begin
                run_op(OP_BTRRD, rand_addr(), rand_word());
            end

            // DRD of the first block word ends block mode
            test_name = "block_end";
            run_op(OP_DRD, start, rand_word());
            run_op(OP_BTRRD, pick_written(), rand_word()); // Sends its own address

            test_name = "unimpl";
            run_op(rand_unimpl(), rand_addr(), rand_word());
        end

        $display("Ops run: %0d, checks: %0d, errors: %0d", ops, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
